// ==== build.f ====
+incdir+include
verilog/iagc_cmd_pkg.sv
verilog/iagc_ctrl_pkg.sv
verilog/iagc_cmd_decode.sv
verilog/iagc_control.sv
verilog/iagc_capture.sv
verilog/iagc_top.sv
sim/iagc_tb.sv

// ==== build.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module iagc_tb \
    -f build.f --Mdir obj_dir -o iagc_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/iagc_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== include/iagc_cfg.svh ====
`ifndef IAGC_CFG_SVH
`define IAGC_CFG_SVH

// Datapath widths
`define IAGC_ADDR_SIZE           8
`define IAGC_SAMPLE_SIZE         12
`define IAGC_DUMP_SIZE           16
`define IAGC_DECIMATOR_SIZE      4
`define IAGC_COUNT_SIZE          16

// Configuration loaded in the RESET and INIT states
`define IAGC_DEF_MEMORY_SIZE     64
`define IAGC_DEF_DECIMATOR       4
`define IAGC_DEF_PHASE_COUNT     256
`define IAGC_DEF_AMPLITUDE_COUNT 256

`endif

// ==== sim/iagc_tb.sv ====
`timescale 1ns/1ns
`include "iagc_cfg.svh"

module iagc_tb;

    localparam int CLOCK_PERIOD = 8;
    localparam int MAX_CYCLES   = 25000; // Longest sampling runs plus dumps, with ample margin
    localparam int WATCHDOG_NS  = MAX_CYCLES * CLOCK_PERIOD;
    localparam int DEPTH        = 1 << `IAGC_ADDR_SIZE;

    logic                      i_clock;
    logic                      i_reset;
    logic                      i_adc_init_done;
    logic                      i_dac_init_done;
    logic                      i_sample;
    logic                      i_cmd_strobe;
    logic [7:0]                i_cmd_byte;
    logic                      i_adc_valid;
    iagc_ctrl_pkg::sample_t    i_adc_data;
    iagc_ctrl_pkg::status_e    o_status;
    iagc_ctrl_pkg::addr_t      o_memory_size;
    iagc_ctrl_pkg::decimator_t o_decimator;
    iagc_ctrl_pkg::count_t     o_phase_count;
    iagc_ctrl_pkg::count_t     o_amplitude_count;
    logic                      o_dump_valid;
    iagc_ctrl_pkg::dump_t      o_dump_data;
    logic                      o_cmd_dropped;

    // Reference model of the configuration and the sample memory
    iagc_ctrl_pkg::sample_t model_mem [DEPTH];
    int                     model_size;
    logic [3:0]             model_dec;
    logic [15:0]            model_pha;
    logic [15:0]            model_amp;
    logic                   dump_err_mode = 1'b0;
    int                     dump_count = 0;
    int                     dump_base = 0;
    int                     error_count = 0;
    logic [31:0]            lfsr = 32'hd546_d569;

    iagc_top UUT (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_adc_init_done   (i_adc_init_done),
        .i_dac_init_done   (i_dac_init_done),
        .i_sample          (i_sample),
        .i_cmd_strobe      (i_cmd_strobe),
        .i_cmd_byte        (i_cmd_byte),
        .i_adc_valid       (i_adc_valid),
        .i_adc_data        (i_adc_data),
        .o_status          (o_status),
        .o_memory_size     (o_memory_size),
        .o_decimator       (o_decimator),
        .o_phase_count     (o_phase_count),
        .o_amplitude_count (o_amplitude_count),
        .o_dump_valid      (o_dump_valid),
        .o_dump_data       (o_dump_data),
        .o_cmd_dropped     (o_cmd_dropped)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        // Galois form of x^32 + x^22 + x^2 + x + 1
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] expected_dump(input int index);
        logic [15:0] word;
        word = {4'b0000, model_mem[index]};
        if (dump_err_mode) begin
            word = word - model_amp; // Negative results wrap
        end
        return word;
    endfunction

    function automatic iagc_ctrl_pkg::status_e target_status(input logic [3:0] op);
        case (op)
            iagc_cmd_pkg::CMD_EMPTY:     return iagc_ctrl_pkg::STATUS_IDLE;
            iagc_cmd_pkg::CMD_RESET:     return iagc_ctrl_pkg::STATUS_RESET;
            iagc_cmd_pkg::CMD_SAMPLE:    return iagc_ctrl_pkg::STATUS_SAMPLE;
            iagc_cmd_pkg::CMD_SET_DEC:   return iagc_ctrl_pkg::STATUS_SET_DEC;
            iagc_cmd_pkg::CMD_CLEAN_MEM: return iagc_ctrl_pkg::STATUS_CLEAN_MEM;
            iagc_cmd_pkg::CMD_DUMP_REF:  return iagc_ctrl_pkg::STATUS_DUMP_REF;
            iagc_cmd_pkg::CMD_DUMP_ERR:  return iagc_ctrl_pkg::STATUS_DUMP_ERR;
            iagc_cmd_pkg::CMD_SET_MEM:   return iagc_ctrl_pkg::STATUS_SET_MEM;
            iagc_cmd_pkg::CMD_SET_PHA:   return iagc_ctrl_pkg::STATUS_SET_PHA;
            iagc_cmd_pkg::CMD_SET_AMP:   return iagc_ctrl_pkg::STATUS_SET_AMP;
            iagc_cmd_pkg::CMD_HALT:      return iagc_ctrl_pkg::STATUS_HALT;
            default:                     return iagc_ctrl_pkg::STATUS_CMD_ERROR;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("Some tests failed");
        $fatal(1, "stopped on error");
    endtask

    task automatic expect_status(input iagc_ctrl_pkg::status_e expected, input string what);
        check_equal(32'(o_status), 32'(expected), what);
    endtask

    task automatic next_cycle();
        @(posedge i_clock);
        #1; // Drive and observe just after the edge
    endtask

    task automatic reset_model();
        model_size = `IAGC_DEF_MEMORY_SIZE;
        model_dec  = 4'(`IAGC_DEF_DECIMATOR);
        model_pha  = 16'(`IAGC_DEF_PHASE_COUNT);
        model_amp  = 16'(`IAGC_DEF_AMPLITUDE_COUNT);
    endtask

    task automatic check_config();
        check_equal(32'(o_memory_size), 32'(model_size), "memory size");
        check_equal(32'(o_decimator), 32'(model_dec), "decimator");
        check_equal(32'(o_phase_count), 32'(model_pha), "phase count");
        check_equal(32'(o_amplitude_count), 32'(model_amp), "amplitude count");
    endtask

    task automatic send_command(input logic [3:0] op, input logic [3:0] param);
        i_cmd_strobe = 1'b1;
        i_cmd_byte   = {op, param};
        next_cycle();
        i_cmd_strobe = 1'b0;
        i_cmd_byte   = 8'h00;
    endtask

    // Walks IDLE, CMD_PARSE and CMD_READ into the target state, one cycle each
    task automatic run_command(input logic [3:0] op, input logic [3:0] param);
        iagc_ctrl_pkg::status_e target;
        target = target_status(op);
        send_command(op, param);
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE while the command is buffered");
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_CMD_PARSE, "CMD_PARSE");
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_CMD_READ, "CMD_READ");
        next_cycle();
        expect_status(target, $sformatf("target state of operation %0d", op));
    endtask

    task automatic config_command(input logic [3:0] op, input logic [3:0] param);
        run_command(op, param);
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after a one-cycle state");
        case (op)
            iagc_cmd_pkg::CMD_SET_MEM: model_size = 1 << ((param > 4'd8) ? 4'd8 : param);
            iagc_cmd_pkg::CMD_SET_DEC: model_dec = param;
            iagc_cmd_pkg::CMD_SET_PHA: model_pha = 16'd1 << param;
            iagc_cmd_pkg::CMD_SET_AMP: model_amp = 16'd1 << param;
            default: ;
        endcase
        check_config();
    endtask

    task automatic sample_memory(input logic use_level);
        int          kept;
        int          valid_seen;
        int          cycles;
        int          step_size;
        logic [31:0] bits;
        kept       = 0;
        valid_seen = 0;
        cycles     = 0;
        step_size  = (model_dec == 4'd0) ? 1 : int'(model_dec);
        if (use_level) begin
            i_sample = 1'b1;
        end else begin
            send_command(iagc_cmd_pkg::CMD_SAMPLE, 4'd0);
        end
        while (kept < model_size && cycles < MAX_CYCLES) begin
            next_cycle();
            i_sample = 1'b0;
            cycles++;
            draw_bits(1, bits);
            i_adc_valid = bits[0];
            draw_bits(`IAGC_SAMPLE_SIZE, bits);
            i_adc_data = bits[`IAGC_SAMPLE_SIZE-1:0];
            // What is driven now is stored at the next edge only while sampling
            if (o_status == iagc_ctrl_pkg::STATUS_SAMPLE && i_adc_valid) begin
                if (valid_seen % step_size == 0) begin
                    model_mem[kept] = i_adc_data;
                    kept++;
                end
                valid_seen++;
            end
        end
        if (kept < model_size) begin
            stop_with_error("SAMPLE did not store a full memory of samples in time");
        end
        next_cycle();
        i_adc_valid = 1'b0;
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after the last kept sample");
    endtask

    task automatic dump_memory(input logic err_mode);
        dump_err_mode = err_mode;
        dump_base     = dump_count;
        run_command(err_mode ? iagc_cmd_pkg::CMD_DUMP_ERR : iagc_cmd_pkg::CMD_DUMP_REF, 4'd0);
        check_equal(32'(o_dump_valid), 32'd0, "no dump word in the first dump cycle");
        next_cycle();
        check_equal(32'(o_dump_valid), 32'd0, "no dump word in the second dump cycle");
        next_cycle();
        repeat (model_size) begin
            check_equal(32'(o_dump_valid), 32'd1, "consecutive dump words");
            next_cycle();
        end
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after the last dump word");
        check_equal(32'(o_dump_valid), 32'd0, "dump valid low after the dump");
        check_equal(32'(dump_count - dump_base), 32'(model_size), "number of dump words");
    endtask

    task automatic clean_memory();
        run_command(iagc_cmd_pkg::CMD_CLEAN_MEM, 4'd0);
        repeat (model_size - 1) begin
            next_cycle();
            expect_status(iagc_ctrl_pkg::STATUS_CLEAN_MEM, "CLEAN_MEM while clearing");
        end
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after the last cleared address");
        for (int i = 0; i < model_size; i++) begin
            model_mem[i] = '0;
        end
    endtask

    always @(negedge i_clock) begin
        if (o_dump_valid === 1'b1) begin
            check_equal(32'(o_dump_data), 32'(expected_dump(dump_count - dump_base)),
                        $sformatf("dump word %0d", dump_count - dump_base));
            dump_count = dump_count + 1;
        end
    end

    initial begin
        i_reset         = 1'b1;
        i_adc_init_done = 1'b0;
        i_dac_init_done = 1'b0;
        i_sample        = 1'b0;
        i_cmd_strobe    = 1'b0;
        i_cmd_byte      = 8'h00;
        i_adc_valid     = 1'b0;
        i_adc_data      = '0;
        reset_model();

        $display("Test 1: reset, converter init and defaults");
        repeat (10) next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_RESET, "RESET while reset is held");
        check_equal(32'(o_dump_valid), 32'd0, "dump valid low in reset");
        check_equal(32'(o_cmd_dropped), 32'd0, "drop flag low in reset");
        i_reset = 1'b0;
        repeat (6) begin
            next_cycle();
            expect_status(iagc_ctrl_pkg::STATUS_INIT, "INIT until both converters are ready");
        end
        i_adc_init_done = 1'b1;
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_INIT, "INIT with only the ADC ready");
        i_dac_init_done = 1'b1;
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after both converters are ready");
        check_config();

        $display("Test 2: configuration commands, unknown codes, dropped command");
        config_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd5);
        config_command(iagc_cmd_pkg::CMD_SET_DEC, 4'd3);
        config_command(iagc_cmd_pkg::CMD_SET_PHA, 4'd10);
        config_command(iagc_cmd_pkg::CMD_SET_AMP, 4'd7);
        config_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd12); // Clamped to the full depth
        for (int code = 11; code < 16; code++) begin
            config_command(4'(code), 4'd2);
        end
        send_command(iagc_cmd_pkg::CMD_EMPTY, 4'd0);
        check_equal(32'(o_cmd_dropped), 32'd0, "first command accepted");
        i_cmd_strobe = 1'b1;
        i_cmd_byte   = {iagc_cmd_pkg::CMD_SET_MEM, 4'd1};
        next_cycle();
        i_cmd_strobe = 1'b0;
        check_equal(32'(o_cmd_dropped), 32'd1, "second command dropped");
        next_cycle();
        check_equal(32'(o_cmd_dropped), 32'd0, "drop flag lasts one cycle");
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after EMPTY");
        check_config();

        $display("Test 3: decimated sampling and reference dumps");
        config_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd4);
        config_command(iagc_cmd_pkg::CMD_SET_DEC, 4'd0);
        sample_memory(1'b0);
        dump_memory(1'b0);
        config_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd6);
        config_command(iagc_cmd_pkg::CMD_SET_DEC, 4'd1);
        sample_memory(1'b1);
        dump_memory(1'b0);
        config_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd8);
        config_command(iagc_cmd_pkg::CMD_SET_DEC, 4'd3);
        sample_memory(1'b0);
        dump_memory(1'b0);

        $display("Test 4: error dump");
        config_command(iagc_cmd_pkg::CMD_SET_AMP, 4'd11);
        dump_memory(1'b1);

        $display("Test 5: memory clean and reset command");
        clean_memory();
        dump_memory(1'b0);
        dump_memory(1'b1);
        run_command(iagc_cmd_pkg::CMD_RESET, 4'd0);
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_INIT, "INIT after the RESET command");
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after the RESET command");
        reset_model();
        check_config();

        $display("Test 6: halt");
        run_command(iagc_cmd_pkg::CMD_HALT, 4'd0);
        send_command(iagc_cmd_pkg::CMD_SET_MEM, 4'd2);
        i_sample = 1'b1;
        repeat (20) begin
            next_cycle();
            expect_status(iagc_ctrl_pkg::STATUS_HALT, "HALT holds");
        end
        send_command(iagc_cmd_pkg::CMD_SAMPLE, 4'd0);
        expect_status(iagc_ctrl_pkg::STATUS_HALT, "HALT holds after more commands");
        check_config();
        i_reset  = 1'b1;
        i_sample = 1'b0;
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_RESET, "RESET leaves HALT");
        i_reset = 1'b0;
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_INIT, "INIT after reset from HALT");
        next_cycle();
        expect_status(iagc_ctrl_pkg::STATUS_IDLE, "IDLE after reset from HALT");
        check_config();

        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/iagc_capture.sv ====
`timescale 1ns/1ns
`include "iagc_cfg.svh"

module iagc_capture (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  iagc_ctrl_pkg::status_e    i_status,
    input  iagc_ctrl_pkg::addr_t      i_memory_size,
    input  iagc_ctrl_pkg::decimator_t i_decimator,
    input  iagc_ctrl_pkg::count_t     i_amplitude_count,
    input  logic                      i_adc_valid,
    input  iagc_ctrl_pkg::sample_t    i_adc_data,
    output logic                      o_sample_end,
    output logic                      o_clean_end,
    output logic                      o_dump_end,
    output logic                      o_dump_valid,
    output iagc_ctrl_pkg::dump_t      o_dump_data
);

    localparam int DEPTH = 1 << `IAGC_ADDR_SIZE;

    iagc_ctrl_pkg::sample_t     memory [DEPTH];
    iagc_ctrl_pkg::sample_t     read_data;
    iagc_ctrl_pkg::sample_t     write_data;
    iagc_ctrl_pkg::addr_t       addr;
    iagc_ctrl_pkg::addr_t       last_addr;
    iagc_ctrl_pkg::decimator_t  dec_count;
    iagc_ctrl_pkg::decimator_t  dec_reload;
    iagc_ctrl_pkg::dump_t       target;
    logic [`IAGC_ADDR_SIZE-1:0] mem_index;
    logic                       sampling;
    logic                       cleaning;
    logic                       dumping;
    logic                       keep;
    logic                       mem_we;
    logic                       read_en;
    logic                       read_last;
    logic                       read_valid;
    logic                       read_last_q;

    assign sampling = (i_status == iagc_ctrl_pkg::STATUS_SAMPLE);
    assign cleaning = (i_status == iagc_ctrl_pkg::STATUS_CLEAN_MEM);
    assign dumping  = (i_status == iagc_ctrl_pkg::STATUS_DUMP_REF) ||
                      (i_status == iagc_ctrl_pkg::STATUS_DUMP_ERR);

    assign last_addr  = i_memory_size - 1'b1;
    assign mem_index  = addr[`IAGC_ADDR_SIZE-1:0];
    assign dec_reload = (i_decimator == '0) ? '0 : i_decimator - 1'b1; // Zero behaves as one
    assign target     = i_amplitude_count[`IAGC_DUMP_SIZE-1:0];

    // The first valid sample is kept, then every decimator-th one
    assign keep       = sampling && i_adc_valid && (dec_count == '0);
    assign mem_we     = keep || cleaning;
    assign write_data = cleaning ? '0 : i_adc_data;

    assign o_sample_end = keep && (addr == last_addr);
    assign o_clean_end  = cleaning && (addr == last_addr);

    assign read_en   = dumping && (addr < i_memory_size);
    assign read_last = read_en && (addr == last_addr);

    always_ff @(posedge i_clock) begin
        if (i_reset || i_status == iagc_ctrl_pkg::STATUS_IDLE) begin
            addr      <= '0;
            dec_count <= '0;
        end else begin
            if (mem_we || read_en) begin
                addr <= addr + 1'b1;
            end
            if (sampling && i_adc_valid) begin
                dec_count <= keep ? dec_reload : dec_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (mem_we) begin
            memory[mem_index] <= write_data;
        end
        read_data <= memory[mem_index];
    end

    // Second stage lines the end pulse up with the last word
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            read_valid   <= 1'b0;
            read_last_q  <= 1'b0;
            o_dump_valid <= 1'b0;
            o_dump_end   <= 1'b0;
        end else begin
            read_valid   <= read_en;
            read_last_q  <= read_last;
            o_dump_valid <= read_valid;
            o_dump_end   <= read_last_q;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_status == iagc_ctrl_pkg::STATUS_DUMP_ERR) begin
            o_dump_data <= iagc_ctrl_pkg::dump_t'(read_data) - target; // Wraps as two's complement
        end else begin
            o_dump_data <= iagc_ctrl_pkg::dump_t'(read_data);
        end
    end

endmodule

// ==== verilog/iagc_cmd_decode.sv ====
`timescale 1ns/1ns

module iagc_cmd_decode (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_cmd_strobe,
    input  logic [7:0]              i_cmd_byte,
    input  logic                    i_cmd_take,
    output logic                    o_cmd_pending,
    output iagc_cmd_pkg::cmd_op_e   o_cmd_op,
    output iagc_cmd_pkg::cmd_param_t o_cmd_param,
    output logic                    o_cmd_dropped
);

    logic accept;

    // A take in the same cycle frees the entry for the new byte
    assign accept = i_cmd_strobe && (!o_cmd_pending || i_cmd_take);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_cmd_pending <= 1'b0;
            o_cmd_dropped <= 1'b0;
        end else begin
            o_cmd_dropped <= i_cmd_strobe && !accept;
            if (accept) begin
                o_cmd_pending <= 1'b1;
            end else if (i_cmd_take) begin
                o_cmd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            o_cmd_op    <= iagc_cmd_pkg::cmd_op_e'(i_cmd_byte[7:4]); // Validity is judged later
            o_cmd_param <= i_cmd_byte[3:0];
        end
    end

endmodule

// ==== verilog/iagc_cmd_pkg.sv ====
package iagc_cmd_pkg;

    // Operation codes carried in the high nibble of a command byte
    typedef enum logic [3:0] {
        CMD_EMPTY     = 4'd0,  // Spurious empty command seen on the link
        CMD_RESET     = 4'd1,
        CMD_SAMPLE    = 4'd2,
        CMD_SET_DEC   = 4'd3,
        CMD_CLEAN_MEM = 4'd4,
        CMD_DUMP_REF  = 4'd5,
        CMD_DUMP_ERR  = 4'd6,
        CMD_SET_MEM   = 4'd7,
        CMD_SET_PHA   = 4'd8,
        CMD_SET_AMP   = 4'd9,
        CMD_HALT      = 4'd10
    } cmd_op_e;

    // Low nibble of a command byte
    typedef logic [3:0] cmd_param_t;

endpackage

// ==== verilog/iagc_control.sv ====
`timescale 1ns/1ns
`include "iagc_cfg.svh"

module iagc_control (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_adc_init_done,
    input  logic                      i_dac_init_done,
    input  logic                      i_sample,
    input  logic                      i_cmd_pending,
    input  iagc_cmd_pkg::cmd_op_e     i_cmd_op,
    input  iagc_cmd_pkg::cmd_param_t  i_cmd_param,
    input  logic                      i_sample_end,
    input  logic                      i_dump_end,
    input  logic                      i_clean_end,
    output logic                      o_cmd_take,
    output iagc_ctrl_pkg::status_e    o_status,
    output iagc_ctrl_pkg::addr_t      o_memory_size,
    output iagc_ctrl_pkg::decimator_t o_decimator,
    output iagc_ctrl_pkg::count_t     o_phase_count,
    output iagc_ctrl_pkg::count_t     o_amplitude_count
);

    iagc_ctrl_pkg::status_e   status;
    iagc_ctrl_pkg::status_e   next_status;
    iagc_cmd_pkg::cmd_param_t mem_shift;
    logic                     load_defaults;

    // Memory depth cannot exceed the address space
    assign mem_shift = (i_cmd_param > 4'(`IAGC_ADDR_SIZE)) ? 4'(`IAGC_ADDR_SIZE) : i_cmd_param;

    assign load_defaults = (status == iagc_ctrl_pkg::STATUS_RESET) ||
                           (status == iagc_ctrl_pkg::STATUS_INIT);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            status <= iagc_ctrl_pkg::STATUS_RESET;
        end else begin
            status <= next_status;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || load_defaults) begin
            o_memory_size     <= iagc_ctrl_pkg::addr_t'(`IAGC_DEF_MEMORY_SIZE);
            o_decimator       <= iagc_ctrl_pkg::decimator_t'(`IAGC_DEF_DECIMATOR);
            o_phase_count     <= iagc_ctrl_pkg::count_t'(`IAGC_DEF_PHASE_COUNT);
            o_amplitude_count <= iagc_ctrl_pkg::count_t'(`IAGC_DEF_AMPLITUDE_COUNT);
        end else begin
            case (status)
                iagc_ctrl_pkg::STATUS_SET_MEM: o_memory_size <= iagc_ctrl_pkg::addr_t'(1) << mem_shift;
                iagc_ctrl_pkg::STATUS_SET_DEC: o_decimator <= i_cmd_param;
                iagc_ctrl_pkg::STATUS_SET_PHA: o_phase_count <= iagc_ctrl_pkg::count_t'(1) << i_cmd_param;
                iagc_ctrl_pkg::STATUS_SET_AMP: begin
                    o_amplitude_count <= iagc_ctrl_pkg::count_t'(1) << i_cmd_param;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        next_status = status;
        case (status)
            iagc_ctrl_pkg::STATUS_RESET: next_status = iagc_ctrl_pkg::STATUS_INIT;
            iagc_ctrl_pkg::STATUS_INIT: begin
                if (i_adc_init_done && i_dac_init_done) begin
                    next_status = iagc_ctrl_pkg::STATUS_IDLE;
                end
            end
            iagc_ctrl_pkg::STATUS_IDLE: begin
                // A waiting command wins over a sample request
                if (i_cmd_pending) begin
                    next_status = iagc_ctrl_pkg::STATUS_CMD_PARSE;
                end else if (i_sample) begin
                    next_status = iagc_ctrl_pkg::STATUS_SAMPLE;
                end
            end
            iagc_ctrl_pkg::STATUS_CMD_PARSE: next_status = iagc_ctrl_pkg::STATUS_CMD_READ;
            iagc_ctrl_pkg::STATUS_CMD_READ: begin
                case (i_cmd_op)
                    iagc_cmd_pkg::CMD_EMPTY:     next_status = iagc_ctrl_pkg::STATUS_IDLE;
                    iagc_cmd_pkg::CMD_RESET:     next_status = iagc_ctrl_pkg::STATUS_RESET;
                    iagc_cmd_pkg::CMD_SAMPLE:    next_status = iagc_ctrl_pkg::STATUS_SAMPLE;
                    iagc_cmd_pkg::CMD_SET_DEC:   next_status = iagc_ctrl_pkg::STATUS_SET_DEC;
                    iagc_cmd_pkg::CMD_CLEAN_MEM: next_status = iagc_ctrl_pkg::STATUS_CLEAN_MEM;
                    iagc_cmd_pkg::CMD_DUMP_REF:  next_status = iagc_ctrl_pkg::STATUS_DUMP_REF;
                    iagc_cmd_pkg::CMD_DUMP_ERR:  next_status = iagc_ctrl_pkg::STATUS_DUMP_ERR;
                    iagc_cmd_pkg::CMD_SET_MEM:   next_status = iagc_ctrl_pkg::STATUS_SET_MEM;
                    iagc_cmd_pkg::CMD_SET_PHA:   next_status = iagc_ctrl_pkg::STATUS_SET_PHA;
                    iagc_cmd_pkg::CMD_SET_AMP:   next_status = iagc_ctrl_pkg::STATUS_SET_AMP;
                    iagc_cmd_pkg::CMD_HALT:      next_status = iagc_ctrl_pkg::STATUS_HALT;
                    default:                     next_status = iagc_ctrl_pkg::STATUS_CMD_ERROR;
                endcase
            end
            iagc_ctrl_pkg::STATUS_SAMPLE: begin
                if (i_sample_end) begin
                    next_status = iagc_ctrl_pkg::STATUS_IDLE;
                end
            end
            iagc_ctrl_pkg::STATUS_DUMP_REF,
            iagc_ctrl_pkg::STATUS_DUMP_ERR: begin
                if (i_dump_end) begin
                    next_status = iagc_ctrl_pkg::STATUS_IDLE;
                end
            end
            iagc_ctrl_pkg::STATUS_CLEAN_MEM: begin
                if (i_clean_end) begin
                    next_status = iagc_ctrl_pkg::STATUS_IDLE;
                end
            end
            iagc_ctrl_pkg::STATUS_HALT: next_status = iagc_ctrl_pkg::STATUS_HALT; // Only i_reset leaves
            default: next_status = iagc_ctrl_pkg::STATUS_IDLE; // Error and SET states last one cycle
        endcase
    end

    assign o_cmd_take = (status == iagc_ctrl_pkg::STATUS_CMD_READ);
    assign o_status   = status;

endmodule

// ==== verilog/iagc_ctrl_pkg.sv ====
`include "iagc_cfg.svh"

package iagc_ctrl_pkg;

    typedef enum logic [3:0] {
        STATUS_RESET     = 4'd0,
        STATUS_INIT      = 4'd1,
        STATUS_IDLE      = 4'd2,
        STATUS_SAMPLE    = 4'd3,
        STATUS_CMD_PARSE = 4'd4,
        STATUS_CMD_READ  = 4'd5,
        STATUS_CMD_ERROR = 4'd6,
        STATUS_DUMP_REF  = 4'd7,
        STATUS_DUMP_ERR  = 4'd8,
        STATUS_CLEAN_MEM = 4'd9,
        STATUS_SET_MEM   = 4'd10,
        STATUS_SET_DEC   = 4'd11,
        STATUS_SET_PHA   = 4'd12,
        STATUS_SET_AMP   = 4'd13,
        STATUS_HALT      = 4'd14
    } status_e;

    // One bit wider than the address so the full depth fits
    typedef logic [`IAGC_ADDR_SIZE:0]        addr_t;

    typedef logic [`IAGC_DECIMATOR_SIZE-1:0] decimator_t;
    typedef logic [`IAGC_COUNT_SIZE-1:0]     count_t;
    typedef logic [`IAGC_SAMPLE_SIZE-1:0]    sample_t;
    typedef logic [`IAGC_DUMP_SIZE-1:0]      dump_t;

endpackage

// ==== verilog/iagc_top.sv ====
`timescale 1ns/1ns

module iagc_top (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_adc_init_done,
    input  logic                      i_dac_init_done,
    input  logic                      i_sample,
    input  logic                      i_cmd_strobe,
    input  logic [7:0]                i_cmd_byte,
    input  logic                      i_adc_valid,
    input  iagc_ctrl_pkg::sample_t    i_adc_data,
    output iagc_ctrl_pkg::status_e    o_status,
    output iagc_ctrl_pkg::addr_t      o_memory_size,
    output iagc_ctrl_pkg::decimator_t o_decimator,
    output iagc_ctrl_pkg::count_t     o_phase_count,
    output iagc_ctrl_pkg::count_t     o_amplitude_count,
    output logic                      o_dump_valid,
    output iagc_ctrl_pkg::dump_t      o_dump_data,
    output logic                      o_cmd_dropped
);

    logic                     cmd_pending;
    logic                     cmd_take;
    iagc_cmd_pkg::cmd_op_e    cmd_op;
    iagc_cmd_pkg::cmd_param_t cmd_param;
    logic                     sample_end;
    logic                     dump_end;
    logic                     clean_end;

    iagc_cmd_decode u_cmd_decode (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_cmd_strobe  (i_cmd_strobe),
        .i_cmd_byte    (i_cmd_byte),
        .i_cmd_take    (cmd_take),
        .o_cmd_pending (cmd_pending),
        .o_cmd_op      (cmd_op),
        .o_cmd_param   (cmd_param),
        .o_cmd_dropped (o_cmd_dropped)
    );

    iagc_control u_control (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_adc_init_done   (i_adc_init_done),
        .i_dac_init_done   (i_dac_init_done),
        .i_sample          (i_sample),
        .i_cmd_pending     (cmd_pending),
        .i_cmd_op          (cmd_op),
        .i_cmd_param       (cmd_param),
        .i_sample_end      (sample_end),
        .i_dump_end        (dump_end),
        .i_clean_end       (clean_end),
        .o_cmd_take        (cmd_take),
        .o_status          (o_status),
        .o_memory_size     (o_memory_size),
        .o_decimator       (o_decimator),
        .o_phase_count     (o_phase_count),
        .o_amplitude_count (o_amplitude_count)
    );

    iagc_capture u_capture (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_status          (o_status),
        .i_memory_size     (o_memory_size),
        .i_decimator       (o_decimator),
        .i_amplitude_count (o_amplitude_count),
        .i_adc_valid       (i_adc_valid),
        .i_adc_data        (i_adc_data),
        .o_sample_end      (sample_end),
        .o_clean_end       (clean_end),
        .o_dump_end        (dump_end),
        .o_dump_valid      (o_dump_valid),
        .o_dump_data       (o_dump_data)
    );

endmodule
